// File: all.f
link_pkg.sv
pkt_pkg.sv
sym_decoder.sv
flit_rx.sv
pkt_assembler.sv
spinn_link_rx.sv
tb_clk_gen.sv
tb_spinn_link_rx.sv

// File: tb_spinn_link_rx.sv
// sender model assumes the 3-cycle ack path; every wait is bounded, a timeout skips the rest
`timescale 1ns/1ps

module tb_spinn_link_rx;
  import link_pkg::*;
  import pkt_pkg::*;

  localparam int n_tests      = 9;
  localparam int ack_limit    = 40;  // cycles, ack is due after 3
  localparam int pkt_limit    = 40;  // cycles from eop ack to pkt_vld
  localparam int reset_limit  = 100;
  localparam int quiet_cycles = 10;
  localparam logic [sym_w-1:0] sym_bad = 7'b0000101;  // two wires but no legal code

  typedef enum logic [1:0] {inj_none, inj_bad, inj_early} inj_t;

  // one row of the stimulus table
  typedef struct packed {
    logic       long_pkt;    // length flag in nibble 0
    inj_t       inject;      // what to spoil
    logic [4:0] inj_idx;     // nibble index of the fault
    logic [7:0] hold;        // stall cycles, 0 = no back-pressure
    logic       expect_pkt;  // a packet should come out
  } test_t;

  logic             CLK_IN;
  logic             RESET_IN;
  logic [sym_w-1:0] sl_data;
  logic             sl_ack;
  pkt_t             pkt;
  logic             pkt_vld;
  logic             pkt_rdy;

  logic [sym_w-1:0] nrz;       // current wire levels
  logic             ack_last;  // last ack level seen
  logic [3:0]       nib_q [long_nibbles];
  int               errors;
  int               failed_tests;
  bit               timed_out;
  test_t            tests [n_tests];
  string            test_name [n_tests];

  tb_clk_gen i_clk_gen (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN)
  );

  spinn_link_rx i_dut (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack),
    .pkt      (pkt),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy)
  );

  // ------------------------------
  // checks and waits
  // ------------------------------
  task automatic check_value(input string name, input logic [pkt_w-1:0] got,
                             input logic [pkt_w-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    errors++;
    timed_out = 1'b1;  // later steps are skipped
  endtask

  // next change of sl_ack against the last level seen
  task automatic wait_ack(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge CLK_IN);
      if (sl_ack !== ack_last) begin
        seen = 1'b1;
        ack_last = sl_ack;
      end
      n++;
    end
  endtask

  // flip the two wires of a code, 2 ns after the edge
  task automatic drive_symbol(input logic [sym_w-1:0] code);
    @(posedge CLK_IN);
    #2;
    nrz = nrz ^ code;
    sl_data = nrz;
  endtask

  task automatic send_symbol(input logic [sym_w-1:0] code);
    bit seen;
    if (timed_out) return;
    drive_symbol(code);
    wait_ack(ack_limit, seen);
    if (!seen) report_timeout("sl_ack did not toggle after a symbol was sent");
  endtask

  // wait for pkt_vld, compare, and let the handshake finish if ready
  task automatic collect_packet(input pkt_t exp, input string name);
    int n;
    bit seen;
    if (timed_out) return;
    seen = 1'b0;
    n = 0;
    while (!seen && n < pkt_limit) begin
      @(negedge CLK_IN);
      seen = pkt_vld;
      n++;
    end
    if (!seen) begin
      report_timeout("pkt_vld never rose for an expected packet");
      return;
    end
    check_value(name, pkt, exp);
    if (pkt_rdy) @(posedge CLK_IN);  // packet taken here
  endtask

  // no packet may show up
  task automatic expect_quiet();
    bit seen;
    if (timed_out) return;
    seen = 1'b0;
    repeat (quiet_cycles) begin
      @(negedge CLK_IN);
      if (pkt_vld) seen = 1'b1;
    end
    check_value("pkt_vld", seen, 0);
  endtask

  // ------------------------------
  // packet stimulus
  // ------------------------------
  // random nibbles, expected value from the nibble order rule
  task automatic make_packet(input logic long_pkt, output int n, output pkt_t exp);
    exp = '0;
    n = long_pkt ? long_nibbles : short_nibbles;
    for (int i = 0; i < n; i++) begin
      nib_q[i] = 4'($urandom_range(15, 0));
      if (i == 0) nib_q[i][long_bit] = long_pkt;  // length flag
      exp[4*i +: 4] = nib_q[i];  // payload stays zero when short
    end
  endtask

  task automatic send_packet(input test_t t, input int n);
    for (int i = 0; i < n; i++) begin
      if (t.inject == inj_early && i == t.inj_idx) break;  // eop comes too soon
      if (t.inject == inj_bad && i == t.inj_idx) begin
        send_symbol(sym_bad);
      end else begin
        send_symbol(sym_code[nib_q[i]]);
      end
    end
    send_symbol(sym_eop);
  endtask

  task automatic run_test(input test_t t);
    pkt_t exp_a;
    pkt_t exp_b;
    int   n;
    bit   seen;
    if (t.hold != 0) begin
      @(posedge CLK_IN);
      #2 pkt_rdy = 1'b0;  // output blocked from the start
    end
    make_packet(t.long_pkt, n, exp_a);
    send_packet(t, n);
    if (!t.expect_pkt) begin
      expect_quiet();
      return;
    end
    collect_packet(exp_a, "pkt");
    if (t.hold == 0 || timed_out) return;

    // ------------------------------
    // back-pressure: a held, b in the assembler
    // ------------------------------
    make_packet(1'b1, n, exp_b);
    send_packet(t, n);
    send_symbol(sym_eop);  // fills the flit register
    if (timed_out) return;
    drive_symbol(sym_eop);  // this one must stall
    wait_ack(t.hold, seen);
    if (seen) begin
      $display("sl_ack kept toggling while the packet port was blocked");
      errors++;
    end
    check_value("pkt", pkt, exp_a);  // still the first packet
    check_value("pkt_vld", pkt_vld, 1);
    @(posedge CLK_IN);
    #2 pkt_rdy = 1'b1;
    collect_packet(exp_a, "pkt");
    collect_packet(exp_b, "pkt");
    wait_ack(ack_limit, seen);
    if (!seen) report_timeout("sl_ack did not resume after pkt_rdy returned");
  endtask

  // reset exit gives one ack with no symbol
  task automatic check_reset_ack();
    bit seen;
    int extra;
    wait_ack(ack_limit, seen);
    if (!seen) begin
      report_timeout("no sl_ack toggle after reset was released");
      return;
    end
    extra = 0;
    repeat (quiet_cycles) begin
      @(negedge CLK_IN);
      if (sl_ack !== ack_last) extra++;
      ack_last = sl_ack;
      check_value("pkt_vld", pkt_vld, 0);
    end
    check_value("sl_ack extra toggles", extra, 0);
  endtask

  task automatic print_result(input string name, input int first_err);
    if (errors > first_err) begin
      failed_tests++;
      $display("test %-24s FAIL (%0d errors)", name, errors - first_err);
    end else begin
      $display("test %-24s ok", name);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int n;
    int first_err;
    int run_cnt;
    sl_data      = '0;
    pkt_rdy      = 1'b1;
    nrz          = '0;
    ack_last     = 1'b0;
    errors       = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    void'($urandom(52976));

    // long, inject, index, hold, expect
    tests[0] = '{1'b0, inj_none,  5'd0, 8'd0,  1'b1};
    test_name[0] = "short packet";
    tests[1] = '{1'b1, inj_none,  5'd0, 8'd0,  1'b1};
    test_name[1] = "long packet";
    tests[2] = '{1'b1, inj_bad,   5'd7, 8'd0,  1'b0};
    test_name[2] = "error mid packet";
    tests[3] = '{1'b0, inj_none,  5'd0, 8'd0,  1'b1};
    test_name[3] = "good after error";
    tests[4] = '{1'b0, inj_bad,   5'd0, 8'd0,  1'b0};
    test_name[4] = "error on nibble 0";
    tests[5] = '{1'b1, inj_none,  5'd0, 8'd0,  1'b1};
    test_name[5] = "long after error";
    tests[6] = '{1'b0, inj_early, 5'd6, 8'd0,  1'b0};
    test_name[6] = "early eop";
    tests[7] = '{1'b1, inj_none,  5'd0, 8'd0,  1'b1};
    test_name[7] = "good after early eop";
    tests[8] = '{1'b0, inj_none,  5'd0, 8'd30, 1'b1};
    test_name[8] = "back-pressure";

    n = 0;
    while (RESET_IN !== 1'b0 && n < reset_limit) begin
      @(posedge CLK_IN);
      n++;
    end
    if (RESET_IN !== 1'b0) report_timeout("reset was never released");

    first_err = errors;
    run_cnt = 1;
    if (!timed_out) check_reset_ack();
    print_result("reset ack", first_err);

    for (int i = 0; i < n_tests && !timed_out; i++) begin
      first_err = errors;
      run_test(tests[i]);
      print_result(test_name[i], first_err);
      run_cnt++;
    end

    $display("tests run %0d, failed %0d, errors %0d", run_cnt, failed_tests, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
// free-running 20 ns clock, reset held high for the first 10 rising edges then released
`timescale 1ns/1ps

module tb_clk_gen (
  output logic CLK_IN,
  output logic RESET_IN
);

  localparam int half_period = 10;  // ns
  localparam int reset_cycles = 10;

  initial begin
    CLK_IN = 1'b0;
    forever #half_period CLK_IN = ~CLK_IN;
  end

  // release a little after the edge, like every other input
  initial begin
    RESET_IN = 1'b1;
    repeat (reset_cycles) @(posedge CLK_IN);
    #2 RESET_IN = 1'b0;
  end

endmodule

// File: spinn_link_rx.sv
// spinnaker link receiver; back-pressure on pkt_rdy stalls the link by holding the ack
`timescale 1ns/1ps

module spinn_link_rx (
  input  logic                       CLK_IN,
  input  logic                       RESET_IN,

  // ------------------------------
  // chip-to-chip link
  // ------------------------------
  input  logic [link_pkg::sym_w-1:0] sl_data,  // 2-of-7 nrz wires
  output logic                       sl_ack,   // toggle per symbol

  // ------------------------------
  // packet port
  // ------------------------------
  output pkt_pkg::pkt_t              pkt,
  output logic                       pkt_vld,
  input  logic                       pkt_rdy
);
  import link_pkg::*;

  flit_t flit;      // symbol from the link side
  logic  flit_rdy;  // assembler can take it

  // sync, nrz to rtz and ack
  flit_rx i_flit_rx (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack),
    .flit     (flit),
    .flit_rdy (flit_rdy)
  );

  // decode and build packets
  pkt_assembler i_pkt_assembler (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flit     (flit),
    .flit_rdy (flit_rdy),
    .pkt      (pkt),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy)
  );

endmodule

// File: pkt_assembler.sv
// packet length is taken from nibble 0 only; an eop at the wrong count drops the whole packet
`timescale 1ns/1ps

module pkt_assembler (
  input  logic            CLK_IN,
  input  logic            RESET_IN,
  input  link_pkg::flit_t flit,      // from flit_rx
  output logic            flit_rdy,
  output pkt_pkg::pkt_t   pkt,       // assembled packet
  output logic            pkt_vld,
  input  logic            pkt_rdy
);
  import link_pkg::*;
  import pkt_pkg::*;

  sym_class_t       cls;       // decoded current flit
  logic             accept;    // flit handshake
  logic             dat_flit;  // accepted data nibble
  logic             eop_flit;  // accepted end-of-packet
  logic             bad_flit;  // accepted error symbol
  logic             exp_eop;   // count says eop is due
  logic [4:0]       nib_cnt;   // nibbles so far, starts at 1
  logic             long_pkt;  // length flag from nibble 0
  logic [pkt_w-1:0] pkt_buf;   // shift buffer, newest nibble on top
  logic             pkt_busy;  // output register still held
  logic             send_pkt;  // packet complete, wants the output
  asm_state_t       state;

  sym_decoder i_sym_decoder (
    .sym (flit.sym),
    .cls (cls)
  );

  // ------------------------------
  // flit qualification
  // ------------------------------
  assign accept   = flit.vld && flit_rdy;
  assign dat_flit = accept && cls.is_data;
  assign eop_flit = accept && cls.is_eop;
  assign bad_flit = accept && cls.is_bad;

  // short eop after 10, any eop after 18
  assign exp_eop = (!long_pkt && (nib_cnt == 5'(short_nibbles)))
                || (nib_cnt == 5'(long_nibbles));

  assign pkt_busy = pkt_vld && !pkt_rdy;

  always_comb begin
    case (state)
      st_transfer: send_pkt = eop_flit && exp_eop;  // fresh packet
      st_wait:     send_pkt = 1'b1;                 // retry until free
      default:     send_pkt = 1'b0;
    endcase
  end

  // ------------------------------
  // flit ready
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_rdy <= 1'b0;
    end else begin
      case (state)
        st_transfer: begin
          if (send_pkt && pkt_busy) begin
            flit_rdy <= 1'b0;  // stall the link while output full
          end
        end
        st_wait: begin
          if (!pkt_busy) begin
            flit_rdy <= 1'b1;
          end
        end
        default: begin
          flit_rdy <= 1'b1;
        end
      endcase
    end
  end

  // ------------------------------
  // nibble count and length
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      nib_cnt <= 5'd1;
    end else if (state != st_transfer) begin
      nib_cnt <= 5'd1;  // nibble 0 is taken in idle
    end else if (dat_flit) begin
      nib_cnt <= nib_cnt + 5'd1;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      long_pkt <= 1'b0;
    end else if ((state == st_idle) && dat_flit) begin
      long_pkt <= cls.nibble[long_bit];
    end
  end

  // nibble i ends at bits 4i+3:4i once the packet is complete
  always_ff @(posedge CLK_IN) begin
    if (dat_flit) begin
      pkt_buf <= {cls.nibble, pkt_buf[pkt_w-1:4]};
    end
  end

  // ------------------------------
  // packet output
  // ------------------------------
  always_ff @(posedge CLK_IN) begin
    if (send_pkt && !pkt_busy) begin
      if (long_pkt) begin
        pkt <= pkt_t'(pkt_buf);
      end else begin
        pkt <= pkt_t'(pkt_buf >> (pkt_w - 4 * short_nibbles));  // payload zero
      end
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_vld <= 1'b0;
    end else if (!pkt_busy) begin
      pkt_vld <= send_pkt;
    end
  end

  // ------------------------------
  // fsm
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= st_start;
    end else begin
      case (state)
        st_start: begin
          state <= st_idle;
        end
        st_idle: begin
          if (dat_flit) begin
            state <= st_transfer;  // first nibble
          end else if (bad_flit) begin
            state <= st_drop;
          end
        end
        st_transfer: begin
          if (bad_flit) begin
            state <= st_drop;
          end else if (eop_flit) begin
            if (exp_eop && pkt_busy) begin
              state <= st_wait;  // complete but output full
            end else begin
              state <= st_idle;  // sent, or early eop dropped
            end
          end
        end
        st_wait: begin
          if (!pkt_busy) begin
            state <= st_idle;
          end
        end
        st_drop: begin
          if (eop_flit) begin
            state <= st_idle;  // resync on eop
          end
        end
      endcase
    end
  end

  // packet held steady under back-pressure
  a_pkt_hold: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld && !pkt_rdy) |=> (pkt_vld && $stable(pkt)));

  // no stray encodings in the 3-bit state register
  a_state_legal: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    state inside {st_start, st_idle, st_transfer, st_wait, st_drop});

endmodule

// File: flit_rx.sv
// sender must change exactly two wires per symbol and wait for each ack toggle before the next
`timescale 1ns/1ps

module flit_rx (
  input  logic                       CLK_IN,
  input  logic                       RESET_IN,
  input  logic [link_pkg::sym_w-1:0] sl_data,   // nrz 2-of-7 wires, asynchronous
  output logic                       sl_ack,    // toggles once per accepted symbol
  output link_pkg::flit_t            flit,      // toward the assembler
  input  logic                       flit_rdy
);
  import link_pkg::*;

  logic [sym_w-1:0] sync_q1;     // first sync stage
  logic [sym_w-1:0] sync_q2;     // second sync stage, safe to use
  logic [sym_w-1:0] nrz_ref;     // last accepted nrz value
  logic [sym_w-1:0] rtz;         // changed wires since last symbol
  logic             new_sym;     // two or more wires changed
  logic             run;         // low only in the start cycle
  logic             busy;        // flit held, assembler not taking it
  logic             load;        // take the symbol this edge
  logic             send_ack;
  logic             flit_vld_q;
  logic [sym_w-1:0] flit_sym_q;

  // ------------------------------
  // synchronizer
  // ------------------------------
  always_ff @(posedge CLK_IN) begin
    sync_q1 <= sl_data;
    sync_q2 <= sync_q1;
  end

  // ------------------------------
  // nrz to rtz
  // ------------------------------
  assign rtz     = sync_q2 ^ nrz_ref;
  assign new_sym = ($countones(rtz) > 1);  // single wire: still in flight

  assign busy     = flit_vld_q && !flit_rdy;
  assign load     = run && new_sym && !busy;
  assign send_ack = !run || load;  // start cycle gives the extra toggle

  // start flag, mimics the chip's ack on reset exit
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // tracks the wires during reset, then only on accepted symbols
  always_ff @(posedge CLK_IN) begin
    if (!run || load) begin
      nrz_ref <= sync_q2;
    end
  end

  // ------------------------------
  // link acknowledge
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sl_ack <= 1'b0;
    end else if (send_ack) begin
      sl_ack <= ~sl_ack;  // sender may now move on
    end
  end

  // ------------------------------
  // flit register
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_vld_q <= 1'b0;
    end else if (!busy) begin
      flit_vld_q <= load;  // empties when taken and nothing new
    end
  end

  always_ff @(posedge CLK_IN) begin
    if (load) begin
      flit_sym_q <= rtz;
    end
  end

  assign flit = '{vld: flit_vld_q, sym: flit_sym_q};

  // held flit must not change until the assembler takes it
  a_flit_hold: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (flit.vld && !flit_rdy) |=> (flit.vld && $stable(flit.sym)));

endmodule

// File: sym_decoder.sv
// purely combinational; input is an rtz symbol, codes outside the 2-of-7 table are flagged bad
`timescale 1ns/1ps

module sym_decoder (
  input  logic [link_pkg::sym_w-1:0] sym,  // rtz symbol
  output link_pkg::sym_class_t       cls   // flags and nibble
);
  import link_pkg::*;

  // ------------------------------
  // classification
  // ------------------------------
  // data   -> is_data with nibble
  // eop    -> is_eop
  // others with 2+ bits -> is_bad
  // zero or one bit     -> nothing, symbol incomplete
  always_comb begin
    cls = '0;

    // look up the data table, at most one entry can match
    for (int i = 0; i < 16; i++) begin
      if (sym == sym_code[i]) begin
        cls.is_data = 1'b1;
        cls.nibble  = 4'(i);
      end
    end

    if (sym == sym_eop) begin
      cls.is_eop = 1'b1;
    end else if (!cls.is_data && ($countones(sym) > 1)) begin
      cls.is_bad = 1'b1;  // e.g. three wires, or an illegal pair
    end
  end

endmodule

// File: pkt_pkg.sv
// packet-level definitions; short packets carry no payload, long ones a 32-bit payload
package pkt_pkg;

  // ------------------------------
  // packet sizes
  // ------------------------------
  localparam int pkt_w         = 72;  // full packet, long format
  localparam int short_nibbles = 10;  // ctrl + key
  localparam int long_nibbles  = 18;  // ctrl + key + payload

  // length flag, bit position inside ctrl
  localparam int long_bit = 1;

  // ------------------------------
  // packet layout
  // ------------------------------
  // nibble 0 lands in ctrl[3:0], ctrl sits in the lsbs
  typedef struct packed {
    logic [31:0] payload;  // zero for a short packet
    logic [31:0] key;      // routing key
    logic [7:0]  ctrl;     // control byte, length flag inside
  } pkt_t;

  // ------------------------------
  // assembler fsm
  // ------------------------------
  typedef enum logic [2:0] {
    st_start,     // one cycle after reset
    st_idle,      // waiting for the first nibble
    st_transfer,  // collecting nibbles
    st_wait,      // packet done, output still full
    st_drop       // error seen, skip to next eop
  } asm_state_t;

endpackage

// File: link_pkg.sv
// symbol-level definitions; codes assume the standard spinnaker 2-of-7 nrz link, 7 wires
package link_pkg;

  // ------------------------------
  // link geometry
  // ------------------------------
  localparam int sym_w = 7;  // link wires, also rtz symbol width

  // end-of-packet, wires 6 and 5
  localparam logic [sym_w-1:0] sym_eop = 7'b1100000;

  // ------------------------------
  // data codes, indexed by nibble
  // ------------------------------
  // exactly two bits set in each, all distinct from sym_eop
  localparam logic [15:0][sym_w-1:0] sym_code = {
    7'b0001001,  // 15
    7'b0001100,  // 14
    7'b0000110,  // 13
    7'b0000011,  // 12
    7'b1001000,  // 11
    7'b1000100,  // 10
    7'b1000010,  // 9
    7'b1000001,  // 8
    7'b0101000,  // 7
    7'b0100100,  // 6
    7'b0100010,  // 5
    7'b0100001,  // 4
    7'b0011000,  // 3
    7'b0010100,  // 2
    7'b0010010,  // 1
    7'b0010001   // 0
  };

  // one accepted symbol on its way to the assembler
  typedef struct packed {
    logic             vld;  // symbol waiting
    logic [sym_w-1:0] sym;  // rtz form, one bit per changed wire
  } flit_t;

  // decoded view of a symbol
  typedef struct packed {
    logic       is_data;  // one of the sixteen codes
    logic       is_eop;   // end of packet
    logic       is_bad;   // two or more wires, but no legal code
    logic [3:0] nibble;   // valid only with is_data
  } sym_class_t;

endpackage
